// ==== common/rvc_settings.svh ====
`ifndef RVC_SETTINGS_SVH
`define RVC_SETTINGS_SVH

// instruction widths
`define RVC_ILEN 32
`define RVC_CLEN 16

// --------------------
// major opcodes of the expanded instructions
`define RVC_OPC_LOAD   7'b0000011
`define RVC_OPC_STORE  7'b0100011
`define RVC_OPC_OP_IMM 7'b0010011
`define RVC_OPC_OP     7'b0110011
`define RVC_OPC_LUI    7'b0110111
`define RVC_OPC_BRANCH 7'b1100011
`define RVC_OPC_JAL    7'b1101111
`define RVC_OPC_JALR   7'b1100111

`define RVC_EBREAK 32'h00100073

// fixed register numbers
`define RVC_REG_SP 5'd2
`define RVC_REG_RA 5'd1

// quadrant codes in bits 1 to 0
`define RVC_QUAD_0 2'b00
`define RVC_QUAD_1 2'b01
`define RVC_QUAD_2 2'b10

`endif

// ==== common/rvc_pkg.sv ====
`default_nettype none

`include "rvc_settings.svh"

package rvc_pkg;

  // --------------------
  // vector types

  // full width instruction word
  typedef logic [`RVC_ILEN-1:0] instr_t;

  // compressed instruction parcel
  typedef logic [`RVC_CLEN-1:0] cinstr_t;

  // architectural register number
  typedef logic [4:0] reg_t;

  // three bit register field of the CIW, CL, CS, CA and CB formats
  typedef logic [2:0] creg_t;

  typedef logic [2:0] funct3_t;

  // --------------------
  // expander result

  // what one quadrant expander hands back to the top level
  typedef struct packed {
    instr_t instr;
    logic   illegal;
  } rvc_result_t;

  // --------------------
  // helpers

  // compressed register fields only reach x8 to x15
  function automatic reg_t expand_creg(input creg_t creg);
    reg_t full_reg;
    full_reg = {2'b01, creg};
    return full_reg;
  endfunction

endpackage

`default_nettype wire

// ==== hw/rvc_decoder/rvc_quadrant0.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvc_settings.svh"

module rvc_quadrant0 import rvc_pkg::*; (
  input  cinstr_t     cinstr_i,
  output rvc_result_t result_o
);

  funct3_t funct3;
  reg_t    rdp_reg;
  reg_t    rs1p_reg;

  // rd' and rs2' share bits 4 to 2 in this quadrant
  assign funct3   = cinstr_i[15:13];
  assign rdp_reg  = expand_creg(cinstr_i[4:2]);
  assign rs1p_reg = expand_creg(cinstr_i[9:7]);

  always_comb begin
    result_o.instr   = '0;
    result_o.illegal = 1'b0;

    unique case (funct3)
      // c.addi4spn becomes addi rd', x2, nzuimm
      3'b000: begin
        result_o.instr = {
          2'b00,
          cinstr_i[10:7],
          cinstr_i[12:11],
          cinstr_i[5],
          cinstr_i[6],
          2'b00,
          `RVC_REG_SP,
          3'b000,
          rdp_reg,
          `RVC_OPC_OP_IMM
        };
        // zero immediate is reserved
        if (cinstr_i[12:5] == 8'd0) begin
          result_o.illegal = 1'b1;
        end
      end

      // c.lw becomes lw rd' from rs1' plus a word offset
      3'b010: begin
        result_o.instr = {
          5'b00000,
          cinstr_i[5],
          cinstr_i[12:10],
          cinstr_i[6],
          2'b00,
          rs1p_reg,
          3'b010,
          rdp_reg,
          `RVC_OPC_LOAD
        };
      end

      // c.sw becomes sw rs2' to rs1' plus a word offset
      3'b110: begin
        result_o.instr = {
          5'b00000,
          cinstr_i[5],
          cinstr_i[12],
          rdp_reg,
          rs1p_reg,
          3'b010,
          cinstr_i[11:10],
          cinstr_i[6],
          2'b00,
          `RVC_OPC_STORE
        };
      end

      // floating point, RV64 and Zcb slots are not supported
      default: begin
        result_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rvc_decoder/rvc_quadrant1.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvc_settings.svh"

module rvc_quadrant1 import rvc_pkg::*; (
  input  cinstr_t     cinstr_i,
  output rvc_result_t result_o
);

  funct3_t     funct3;
  reg_t        rd_reg;
  reg_t        rdp_reg;
  reg_t        rs2p_reg;
  logic [11:0] imm6_sext;
  logic [19:0] jal_imm;

  assign funct3   = cinstr_i[15:13];
  assign rd_reg   = cinstr_i[11:7];
  assign rdp_reg  = expand_creg(cinstr_i[9:7]);
  assign rs2p_reg = expand_creg(cinstr_i[4:2]);

  // six bit immediate of c.addi, c.li and c.andi
  assign imm6_sext = {{6{cinstr_i[12]}}, cinstr_i[12], cinstr_i[6:2]};

  // --------------------
  // jump offset
  // CJ bits reordered into the jal imm[20|10:1|11|19:12] layout
  assign jal_imm = {
    cinstr_i[12],
    cinstr_i[8],
    cinstr_i[10:9],
    cinstr_i[6],
    cinstr_i[7],
    cinstr_i[2],
    cinstr_i[11],
    cinstr_i[5:3],
    {9{cinstr_i[12]}}
  };

  always_comb begin
    result_o.instr   = '0;
    result_o.illegal = 1'b0;

    unique case (funct3)
      // c.addi and c.nop
      3'b000: begin
        result_o.instr = {imm6_sext, rd_reg, 3'b000, rd_reg, `RVC_OPC_OP_IMM};
      end

      // c.jal links through x1 on RV32
      3'b001: begin
        result_o.instr = {jal_imm, `RVC_REG_RA, `RVC_OPC_JAL};
      end

      // c.li adds to x0
      3'b010: begin
        result_o.instr = {imm6_sext, 5'd0, 3'b000, rd_reg, `RVC_OPC_OP_IMM};
      end

      3'b011: begin
        if (rd_reg == `RVC_REG_SP) begin
          // c.addi16sp scales the immediate by 16
          result_o.instr = {
            {3{cinstr_i[12]}},
            cinstr_i[4:3],
            cinstr_i[5],
            cinstr_i[2],
            cinstr_i[6],
            4'b0000,
            `RVC_REG_SP,
            3'b000,
            `RVC_REG_SP,
            `RVC_OPC_OP_IMM
          };
        end else begin
          // c.lui sign extends bit 17 upward
          result_o.instr = {{15{cinstr_i[12]}}, cinstr_i[6:2], rd_reg, `RVC_OPC_LUI};
        end
      end

      // --------------------
      // arithmetic group on rd'
      3'b100: begin
        unique case (cinstr_i[11:10])
          // srli and srai differ only in bit 30
          2'b00, 2'b01: begin
            result_o.instr = {
              1'b0,
              cinstr_i[10],
              4'b0000,
              cinstr_i[12],
              cinstr_i[6:2],
              rdp_reg,
              3'b101,
              rdp_reg,
              `RVC_OPC_OP_IMM
            };
          end

          2'b10: begin
            result_o.instr = {imm6_sext, rdp_reg, 3'b111, rdp_reg, `RVC_OPC_OP_IMM};
          end

          default: begin
            // register to register forms
            unique case ({cinstr_i[12], cinstr_i[6:5]})
              3'b000: begin
                result_o.instr = {7'b0100000, rs2p_reg, rdp_reg, 3'b000, rdp_reg, `RVC_OPC_OP};
              end
              3'b001: begin
                result_o.instr = {7'b0000000, rs2p_reg, rdp_reg, 3'b100, rdp_reg, `RVC_OPC_OP};
              end
              3'b010: begin
                result_o.instr = {7'b0000000, rs2p_reg, rdp_reg, 3'b110, rdp_reg, `RVC_OPC_OP};
              end
              3'b011: begin
                result_o.instr = {7'b0000000, rs2p_reg, rdp_reg, 3'b111, rdp_reg, `RVC_OPC_OP};
              end
              // subw, addw and the Zcb codes
              default: begin
                result_o.illegal = 1'b1;
              end
            endcase
          end
        endcase
      end

      // c.j discards the link
      3'b101: begin
        result_o.instr = {jal_imm, 5'd0, `RVC_OPC_JAL};
      end

      // c.beqz and c.bnez compare rs1' with x0, bit 13 picks bne
      default: begin
        result_o.instr = {
          {4{cinstr_i[12]}},
          cinstr_i[6:5],
          cinstr_i[2],
          5'd0,
          rdp_reg,
          2'b00,
          cinstr_i[13],
          cinstr_i[11:10],
          cinstr_i[4:3],
          cinstr_i[12],
          `RVC_OPC_BRANCH
        };
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rvc_decoder/rvc_quadrant2.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvc_settings.svh"

module rvc_quadrant2 import rvc_pkg::*; (
  input  cinstr_t     cinstr_i,
  output rvc_result_t result_o
);

  funct3_t funct3;
  reg_t    rd_reg;
  reg_t    rs2_reg;

  assign funct3  = cinstr_i[15:13];
  assign rd_reg  = cinstr_i[11:7];
  assign rs2_reg = cinstr_i[6:2];

  always_comb begin
    result_o.instr   = '0;
    result_o.illegal = 1'b0;

    unique case (funct3)
      3'b000: begin
        result_o.instr = {
          6'b000000,
          cinstr_i[12],
          rs2_reg,
          rd_reg,
          3'b001,
          rd_reg,
          `RVC_OPC_OP_IMM
        };
      end

      // c.lwsp loads from sp plus a scaled offset
      3'b010: begin
        result_o.instr = {
          4'b0000,
          cinstr_i[3:2],
          cinstr_i[12],
          cinstr_i[6:4],
          2'b00,
          `RVC_REG_SP,
          3'b010,
          rd_reg,
          `RVC_OPC_LOAD
        };
        if (rd_reg == 5'd0) begin
          result_o.illegal = 1'b1;
        end
      end

      // --------------------
      // jump, move and add group
      3'b100: begin
        if (rs2_reg != 5'd0) begin
          // bit 12 selects add over mv
          result_o.instr = {
            7'b0000000,
            rs2_reg,
            cinstr_i[12] ? rd_reg : 5'd0,
            3'b000,
            rd_reg,
            `RVC_OPC_OP
          };
        end else if (rd_reg != 5'd0) begin
          // jr links through x0 and jalr through x1
          result_o.instr = {
            12'd0,
            rd_reg,
            3'b000,
            cinstr_i[12] ? `RVC_REG_RA : 5'd0,
            `RVC_OPC_JALR
          };
        end else if (cinstr_i[12]) begin
          result_o.instr = `RVC_EBREAK;
        end else begin
          // jr to x0 is reserved
          result_o.illegal = 1'b1;
        end
      end

      // c.swsp stores rs2 to sp plus a scaled offset
      3'b110: begin
        result_o.instr = {
          4'b0000,
          cinstr_i[8:7],
          cinstr_i[12],
          rs2_reg,
          `RVC_REG_SP,
          3'b010,
          cinstr_i[11:9],
          2'b00,
          `RVC_OPC_STORE
        };
      end

      // fldsp, ldsp, fsdsp, sdsp and the Zcmp and Zcmt space
      default: begin
        result_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hw/rvc_decoder/rvc_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvc_settings.svh"

module rvc_decoder import rvc_pkg::*; (
  input  instr_t instr_i,
  output instr_t instr_o,
  output logic   illegal_instr_o,
  output logic   is_compressed_o
);

  cinstr_t     cinstr;
  rvc_result_t quad0_result;
  rvc_result_t quad1_result;
  rvc_result_t quad2_result;
  rvc_result_t sel_result;

  // only the low parcel carries a compressed instruction
  assign cinstr = instr_i[`RVC_CLEN-1:0];

  rvc_quadrant0 u_quad0 (
    .cinstr_i (cinstr),
    .result_o (quad0_result)
  );

  rvc_quadrant1 u_quad1 (
    .cinstr_i (cinstr),
    .result_o (quad1_result)
  );

  rvc_quadrant2 u_quad2 (
    .cinstr_i (cinstr),
    .result_o (quad2_result)
  );

  // --------------------
  // quadrant select
  always_comb begin
    is_compressed_o    = 1'b1;
    sel_result.instr   = instr_i;
    sel_result.illegal = 1'b0;

    unique case (instr_i[1:0])
      `RVC_QUAD_0: sel_result = quad0_result;
      `RVC_QUAD_1: sel_result = quad1_result;
      `RVC_QUAD_2: sel_result = quad2_result;
      // full width word passes through
      default: is_compressed_o = 1'b0;
    endcase
  end

  // an illegal parcel is handed on as fetched
  assign illegal_instr_o = sel_result.illegal;
  assign instr_o         = sel_result.illegal ? instr_i : sel_result.instr;

endmodule

`default_nettype wire

// ==== verification/tb_rvc_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rvc_settings.svh"

module tb_rvc_decoder import rvc_pkg::*; ();

  // one row of the stimulus table
  typedef struct packed {
    instr_t in_word;
    instr_t exp_word;
    logic   exp_illegal;
    logic   exp_compressed;
    logic   fill_random;
  } test_vec_t;

  logic   clk_i;
  logic   rst_i;
  instr_t instr_drv;
  instr_t instr_out;
  logic   illegal_out;
  logic   compressed_out;

  test_vec_t vectors[$];
  string     names[$];
  integer    seed;
  int        error_count;
  int        check_count;
  logic      table_ready;

  rvc_decoder u_dut (
    .instr_i         (instr_drv),
    .instr_o         (instr_out),
    .illegal_instr_o (illegal_out),
    .is_compressed_o (compressed_out)
  );

  initial clk_i = 1'b0;
  always #5 clk_i = ~clk_i;

  // --------------------
  // reset
  initial begin
    rst_i = 1'b1;
    repeat (16) @(posedge clk_i);
    rst_i <= 1'b0;
  end

  // --------------------
  // RV32I base formats
  function automatic instr_t enc_i(input int imm, input int rs1, input int f3,
                                   input int rd, input logic [6:0] opc);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic instr_t enc_s(input int imm, input int rs2, input int rs1,
                                   input int f3, input logic [6:0] opc);
    return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opc};
  endfunction

  function automatic instr_t enc_b(input int imm, input int rs2, input int rs1,
                                   input int f3, input logic [6:0] opc);
    return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], opc};
  endfunction

  function automatic instr_t enc_r(input int f7, input int rs2, input int rs1,
                                   input int f3, input int rd, input logic [6:0] opc);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic instr_t enc_u(input int imm20, input int rd, input logic [6:0] opc);
    return {imm20[19:0], rd[4:0], opc};
  endfunction

  function automatic instr_t enc_j(input int imm, input int rd, input logic [6:0] opc);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opc};
  endfunction

  // --------------------
  // table entries
  task automatic add_expand(input cinstr_t parcel, input instr_t exp_word, input string name);
    vectors.push_back('{{16'h0000, parcel}, exp_word, 1'b0, 1'b1, 1'b0});
    names.push_back(name);
  endtask

  // expected word is the driven word itself
  task automatic add_illegal(input cinstr_t parcel, input string name);
    vectors.push_back('{{16'h0000, parcel}, '0, 1'b1, 1'b1, 1'b0});
    names.push_back(name);
  endtask

  task automatic add_full(input instr_t word, input logic fill_random, input string name);
    vectors.push_back('{word, '0, 1'b0, 1'b0, fill_random});
    names.push_back(name);
  endtask

  task automatic build_table();
    // quadrant 0
    add_expand(16'h0804, enc_i(16, 2, 0, 9, `RVC_OPC_OP_IMM), "c.addi4spn x9 16");
    add_expand(16'h1FFC, enc_i(1020, 2, 0, 15, `RVC_OPC_OP_IMM), "c.addi4spn x15 1020");
    add_expand(16'h41C8, enc_i(4, 11, 2, 10, `RVC_OPC_LOAD), "c.lw x10 4(x11)");
    add_expand(16'h5FE0, enc_i(124, 15, 2, 8, `RVC_OPC_LOAD), "c.lw x8 124(x15)");
    add_expand(16'hC690, enc_s(8, 12, 13, 2, `RVC_OPC_STORE), "c.sw x12 8(x13)");
    // quadrant 1
    add_expand(16'h0001, enc_i(0, 0, 0, 0, `RVC_OPC_OP_IMM), "c.nop");
    add_expand(16'h12F5, enc_i(-3, 5, 0, 5, `RVC_OPC_OP_IMM), "c.addi x5 -3");
    add_expand(16'h457D, enc_i(31, 0, 0, 10, `RVC_OPC_OP_IMM), "c.li x10 31");
    add_expand(16'h5581, enc_i(-32, 0, 0, 11, `RVC_OPC_OP_IMM), "c.li x11 -32");
    add_expand(16'h6785, enc_u('h00001, 15, `RVC_OPC_LUI), "c.lui x15 1");
    add_expand(16'h7379, enc_u('hFFFFE, 6, `RVC_OPC_LUI), "c.lui x6 -2");
    add_expand(16'h7139, enc_i(-64, 2, 0, 2, `RVC_OPC_OP_IMM), "c.addi16sp -64");
    add_expand(16'h617D, enc_i(496, 2, 0, 2, `RVC_OPC_OP_IMM), "c.addi16sp 496");
    add_expand(16'h3FFD, enc_j(-2, 1, `RVC_OPC_JAL), "c.jal -2");
    add_expand(16'hA201, enc_j(256, 0, `RVC_OPC_JAL), "c.j 256");
    add_expand(16'hABA9, enc_j(1370, 0, `RVC_OPC_JAL), "c.j 1370");
    add_expand(16'hD001, enc_b(-256, 0, 8, 0, `RVC_OPC_BRANCH), "c.beqz x8 -256");
    add_expand(16'hECA9, enc_b(90, 0, 9, 1, `RVC_OPC_BRANCH), "c.bnez x9 90");
    add_expand(16'h8015, enc_i(5, 8, 5, 8, `RVC_OPC_OP_IMM), "c.srli x8 5");
    add_expand(16'h877D, enc_i('h41F, 14, 5, 14, `RVC_OPC_OP_IMM), "c.srai x14 31");
    add_expand(16'h997D, enc_i(-1, 10, 7, 10, `RVC_OPC_OP_IMM), "c.andi x10 -1");
    add_expand(16'h8C05, enc_r('h20, 9, 8, 0, 8, `RVC_OPC_OP), "c.sub x8 x9");
    add_expand(16'h8DB1, enc_r(0, 12, 11, 4, 11, `RVC_OPC_OP), "c.xor x11 x12");
    add_expand(16'h8ED9, enc_r(0, 14, 13, 6, 13, `RVC_OPC_OP), "c.or x13 x14");
    add_expand(16'h8FE1, enc_r(0, 8, 15, 7, 15, `RVC_OPC_OP), "c.and x15 x8");
    // quadrant 2
    add_expand(16'h038E, enc_i(3, 7, 1, 7, `RVC_OPC_OP_IMM), "c.slli x7 3");
    add_expand(16'h4532, enc_i(12, 2, 2, 10, `RVC_OPC_LOAD), "c.lwsp x10 12");
    add_expand(16'h50FE, enc_i(252, 2, 2, 1, `RVC_OPC_LOAD), "c.lwsp x1 252");
    add_expand(16'hDA9A, enc_s(116, 6, 2, 2, `RVC_OPC_STORE), "c.swsp x6 116");
    add_expand(16'hC07E, enc_s(0, 31, 2, 2, `RVC_OPC_STORE), "c.swsp x31 0");
    add_expand(16'hC622, enc_s(12, 8, 2, 2, `RVC_OPC_STORE), "c.swsp x8 12");
    add_expand(16'h852E, enc_r(0, 11, 0, 0, 10, `RVC_OPC_OP), "c.mv x10 x11");
    add_expand(16'h929A, enc_r(0, 6, 5, 0, 5, `RVC_OPC_OP), "c.add x5 x6");
    add_expand(16'h8082, enc_i(0, 1, 0, 0, `RVC_OPC_JALR), "c.jr x1");
    add_expand(16'h9782, enc_i(0, 15, 0, 1, `RVC_OPC_JALR), "c.jalr x15");
    add_expand(16'h9002, 32'h00100073, "c.ebreak");
    // reserved and unsupported encodings
    add_illegal(16'h0000, "all zero parcel");
    add_illegal(16'h0004, "c.addi4spn zero imm");
    add_illegal(16'h507E, "c.lwsp rd x0");
    add_illegal(16'h8002, "c.jr rs1 x0");
    add_illegal(16'h9C05, "c.subw");
    add_illegal(16'h9C25, "c.addw");
    add_illegal(16'h2404, "c.fld");
    add_illegal(16'h6108, "c.flw or c.ld");
    add_illegal(16'hA108, "c.fsd");
    add_illegal(16'hE108, "c.fsw or c.sd");
    add_illegal(16'h2082, "c.fldsp");
    add_illegal(16'h60A2, "c.flwsp or c.ldsp");
    add_illegal(16'hA006, "c.fsdsp");
    add_illegal(16'hE006, "c.fswsp or c.sdsp");
    add_illegal(16'h8008, "zcb c.lbu");
    add_illegal(16'h9C45, "zcb c.mul");
    add_illegal(16'h9C65, "zcb c.zext");
    add_illegal(16'hB8F2, "zcmp cm.push");
    add_illegal(16'hA00A, "zcmt cm.jt");
    // full width words
    add_full(enc_r(0, 10, 10, 0, 10, `RVC_OPC_OP), 1'b0, "add x10 full word");
    repeat (8) add_full('0, 1'b1, "random full word");
  endtask

  task automatic check_outputs(input string name, input instr_t exp_word,
                               input logic exp_ill, input logic exp_cmp);
    check_count = check_count + 3;
    if (instr_out !== exp_word) begin
      error_count = error_count + 1;
      $display("error at %0t ns: %s instr_o expected %08h actual %08h",
               $time, name, exp_word, instr_out);
    end
    if (illegal_out !== exp_ill) begin
      error_count = error_count + 1;
      $display("error at %0t ns: %s illegal_instr_o expected %0b actual %0b",
               $time, name, exp_ill, illegal_out);
    end
    if (compressed_out !== exp_cmp) begin
      error_count = error_count + 1;
      $display("error at %0t ns: %s is_compressed_o expected %0b actual %0b",
               $time, name, exp_cmp, compressed_out);
    end
  endtask

  // --------------------
  // apply loop
  initial begin
    test_vec_t   vec;
    instr_t      drive_word;
    instr_t      exp_word;
    logic [31:0] rnd;
    instr_drv   = '0;
    seed        = 18186;
    error_count = 0;
    check_count = 0;
    table_ready = 1'b0;
    build_table();
    table_ready = 1'b1;
    wait (rst_i === 1'b0);
    for (int i = 0; i < vectors.size(); i++) begin
      vec = vectors[i];
      rnd = $random(seed);
      if (vec.exp_compressed) begin
        drive_word = {rnd[31:16], vec.in_word[15:0]};
      end else if (vec.fill_random) begin
        drive_word = {rnd[31:2], 2'b11};
      end else begin
        drive_word = vec.in_word;
      end
      // illegal parcels and full words come back as driven
      if (vec.exp_illegal || !vec.exp_compressed) begin
        exp_word = drive_word;
      end else begin
        exp_word = vec.exp_word;
      end
      @(posedge clk_i);
      instr_drv <= drive_word;
      @(posedge clk_i);
      check_outputs(names[i], exp_word, vec.exp_illegal, vec.exp_compressed);
    end
    $display("checks: %0d, errors: %0d", check_count, error_count);
    if (error_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

  // reset, two cycles per entry and some slack
  initial begin
    int limit_ns;
    wait (table_ready);
    limit_ns = (16 + 2 * vectors.size() + 20) * 10;
    #(limit_ns);
    $display("timeout: the stimulus table did not finish within %0d ns", limit_ns);
    $display("SOME TESTS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+common
common/rvc_pkg.sv
hw/rvc_decoder/rvc_quadrant0.sv
hw/rvc_decoder/rvc_quadrant1.sv
hw/rvc_decoder/rvc_quadrant2.sv
hw/rvc_decoder/rvc_decoder.sv
verification/tb_rvc_decoder.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 \
  -f filelist.f \
  --top-module tb_rvc_decoder \
  -o sim_tb_rvc_decoder \
  || { echo "build failed"; exit 1; }

sim_out="$(./obj_dir/sim_tb_rvc_decoder)"
printf '%s\n' "$sim_out"
printf '%s\n' "$sim_out" | grep -qx "ALL TESTS PASSED" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }
